//--- Makefile
VERILATOR  ?= verilator
TOP        ?= dbg_monitor_tb
FILELIST   ?= tb.f
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -j 0
PASS_MSG   := NO ERRORS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The run passes only if the pass message shows up as a line of its own
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- dv/dbg_monitor_tb.sv
`timescale 1ns/1ps
`include "dbg_consts.svh"

module dbg_monitor_tb;

  // Six tests of about 60 cycles each, five times over, plus reset
  localparam int TIMEOUT_CYCLES = 6 * 60 * 5 + 200;
  localparam int EXP_PULSES     = 4;
  localparam logic [`DBG_XLEN-1:0] NOP_INSN = 32'h00000013;

  logic                 cov_assert_if = 1'b0;
  logic                 rst_i;
  dbg_pkg::wb_retire_t  wb_i;
  dbg_pkg::dbg_state_t  dbg_i;
  logic                 debug_req_i;
  logic                 irq_pending_i;
  dbg_pkg::predict_t    pred_o;
  logic                 in_wfi_o;
  dbg_pkg::chk_result_t result_o;

  integer seed   = 32'h7909;
  int     cycles = 0;
  int     pulses = 0;
  int     checks;
  int     errors;
  int     tests;
  int     test_errors;
  string  test_name;

  always #2 cov_assert_if = ~cov_assert_if;

  dbg_monitor_top u_dbg_monitor_top (
    .cov_assert_if (cov_assert_if),
    .rst_i         (rst_i),
    .wb_i          (wb_i),
    .dbg_i         (dbg_i),
    .debug_req_i   (debug_req_i),
    .irq_pending_i (irq_pending_i),
    .pred_o        (pred_o),
    .in_wfi_o      (in_wfi_o),
    .result_o      (result_o)
  );

  always @(posedge cov_assert_if) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // Every checker pulse, expected or not
  always @(negedge cov_assert_if) begin
    if (!rst_i && result_o.err) begin
      pulses <= pulses + 1;
    end
  end

  // --------------------
  // Compare tasks
  // --------------------

  task automatic check_cause(input dbg_pkg::dbg_cause_e exp, input dbg_pkg::dbg_cause_e act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error %s: expected %s actual %s", test_name, exp.name(), act.name());
    end
  endtask

  task automatic check_addr(input dbg_pkg::addr_t exp, input dbg_pkg::addr_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error %s: expected %h actual %h", test_name, exp, act);
    end
  endtask

  task automatic check_err(input dbg_pkg::dbg_err_e exp, input dbg_pkg::dbg_err_e act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error %s: expected %s actual %s", test_name, exp.name(), act.name());
    end
  endtask

  task automatic check_bit(input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error %s: expected %b actual %b", test_name, exp, act);
    end
  endtask

  // A pulse is expected exactly when the code is not ERR_NONE
  task automatic check_result(input dbg_pkg::dbg_err_e exp);
    check_bit(exp != dbg_pkg::ERR_NONE, result_o.err);
    check_err(exp, result_o.code);
  endtask

  // --------------------
  // Drivers
  // --------------------

  function automatic dbg_pkg::addr_t rand_pc();
    rand_pc = $random(seed) & 32'hFFFF_FFFC;
  endfunction

  task automatic retire(input logic [`DBG_XLEN-1:0] insn, input dbg_pkg::addr_t pc,
                        input dbg_pkg::addr_t next_pc, input logic trig, input logic illegal);
    dbg_pkg::wb_retire_t w;
    w.valid       = 1'b1;
    w.insn        = insn;
    w.pc          = pc;
    w.next_pc     = next_pc;
    w.fetch_err   = 1'b0;
    w.mpu_ok      = 1'b1;
    w.trigger_hit = trig;
    w.illegal     = illegal;
    @(posedge cov_assert_if);
    wb_i <= w;
    @(posedge cov_assert_if);
    wb_i.valid <= 1'b0;
  endtask

  // Retirement whose fetch faulted or was blocked by the MPU
  task automatic retire_faulted(input logic [`DBG_XLEN-1:0] insn, input dbg_pkg::addr_t pc,
                                input logic fetch_err, input logic mpu_ok);
    dbg_pkg::wb_retire_t w;
    w.valid       = 1'b1;
    w.insn        = insn;
    w.pc          = pc;
    w.next_pc     = pc + 32'd4;
    w.fetch_err   = fetch_err;
    w.mpu_ok      = mpu_ok;
    w.trigger_hit = 1'b0;
    w.illegal     = 1'b0;
    @(posedge cov_assert_if);
    wb_i <= w;
    @(posedge cov_assert_if);
    wb_i.valid <= 1'b0;
  endtask

  task automatic set_debug(input logic mode, input dbg_pkg::dbg_cause_e cause,
                           input logic step, input logic ebreakm, input dbg_pkg::addr_t dpc);
    @(posedge cov_assert_if);
    dbg_i.debug_mode <= mode;
    dbg_i.cause      <= cause;
    dbg_i.step       <= step;
    dbg_i.ebreakm    <= ebreakm;
    dbg_i.dpc        <= dpc;
  endtask

  task automatic set_lines(input logic req, input logic irq);
    @(posedge cov_assert_if);
    debug_req_i   <= req;
    irq_pending_i <= irq;
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge cov_assert_if);
  endtask

  // One more edge, then sample in the middle of the cycle
  task automatic next_sample();
    @(posedge cov_assert_if);
    @(negedge cov_assert_if);
  endtask

  task automatic end_test();
    tests++;
    $display("test %s: %s", test_name, (errors == test_errors) ? "passed" : "failed");
  endtask

  // --------------------
  // Directed tests
  // --------------------

  task automatic test_ebreak_entry();
    dbg_pkg::addr_t pc;
    test_name   = "ebreak_entry";
    test_errors = errors;
    pc = rand_pc();
    set_debug(1'b0, dbg_pkg::CAUSE_NONE, 1'b0, 1'b1, '0);
    retire(`DBG_EBREAK_INSN, pc, pc + 32'd4, 1'b0, 1'b0);
    next_sample();
    check_cause(dbg_pkg::CAUSE_EBREAK, pred_o.cause);
    check_addr(pc, pred_o.dpc);
    set_debug(1'b1, dbg_pkg::CAUSE_EBREAK, 1'b0, 1'b1, pc);
    next_sample();
    check_result(dbg_pkg::ERR_NONE);
    set_debug(1'b0, dbg_pkg::CAUSE_NONE, 1'b0, 1'b1, '0);
    idle(2);
    // Compressed form, core reports the wrong cause
    pc = rand_pc();
    retire(`DBG_CEBREAK_INSN, pc, pc + 32'd2, 1'b0, 1'b0);
    next_sample();
    check_addr(pc, pred_o.dpc);
    set_debug(1'b1, dbg_pkg::CAUSE_HALTREQ, 1'b0, 1'b1, pc);
    next_sample();
    check_result(dbg_pkg::ERR_CAUSE);
    check_cause(dbg_pkg::CAUSE_EBREAK, result_o.exp_cause);
    set_debug(1'b0, dbg_pkg::CAUSE_NONE, 1'b0, 1'b0, '0);
    end_test();
  endtask

  task automatic test_priority();
    dbg_pkg::addr_t pc;
    test_name   = "priority";
    test_errors = errors;
    pc = rand_pc();
    set_debug(1'b0, dbg_pkg::CAUSE_NONE, 1'b0, 1'b1, '0);
    retire(`DBG_EBREAK_INSN, pc, pc + 32'd4, 1'b1, 1'b0);
    next_sample();
    check_cause(dbg_pkg::CAUSE_TRIGGER, pred_o.cause);
    check_addr(pc, pred_o.dpc);
    pc = rand_pc();
    set_debug(1'b0, dbg_pkg::CAUSE_NONE, 1'b0, 1'b0, '0);
    retire(`DBG_EBREAK_INSN, pc, pc + 32'd4, 1'b0, 1'b0);
    next_sample();
    check_cause(dbg_pkg::CAUSE_NONE, pred_o.cause);
    check_addr(pc + 32'd4, pred_o.dpc);
    // A faulted or MPU-blocked fetch never counts as ebreak
    pc = rand_pc();
    set_debug(1'b0, dbg_pkg::CAUSE_NONE, 1'b0, 1'b1, '0);
    retire_faulted(`DBG_EBREAK_INSN, pc, 1'b1, 1'b1);
    next_sample();
    check_cause(dbg_pkg::CAUSE_NONE, pred_o.cause);
    check_addr(pc + 32'd4, pred_o.dpc);
    pc = rand_pc();
    retire_faulted(`DBG_EBREAK_INSN, pc, 1'b0, 1'b0);
    next_sample();
    check_cause(dbg_pkg::CAUSE_NONE, pred_o.cause);
    check_addr(pc + 32'd4, pred_o.dpc);
    set_debug(1'b0, dbg_pkg::CAUSE_NONE, 1'b0, 1'b0, '0);
    end_test();
  endtask

  task automatic test_haltreq();
    dbg_pkg::addr_t pc;
    test_name   = "haltreq";
    test_errors = errors;
    pc = rand_pc();
    retire(NOP_INSN, pc, pc + 32'd4, 1'b0, 1'b0);
    set_lines(1'b1, 1'b0);
    next_sample();
    check_cause(dbg_pkg::CAUSE_HALTREQ, pred_o.cause);
    check_addr(pc + 32'd4, pred_o.dpc);
    set_debug(1'b1, dbg_pkg::CAUSE_HALTREQ, 1'b0, 1'b0, pc + 32'd12);
    next_sample();
    check_result(dbg_pkg::ERR_DPC);
    check_addr(pc + 32'd4, result_o.exp_dpc);
    set_lines(1'b0, 1'b0);
    set_debug(1'b0, dbg_pkg::CAUSE_NONE, 1'b0, 1'b0, '0);
    idle(2);
    end_test();
  endtask

  task automatic test_single_step();
    dbg_pkg::addr_t pc;
    test_name   = "single_step";
    test_errors = errors;
    // An ordinary retirement first brings the held cause back to none
    pc = rand_pc();
    retire(NOP_INSN, pc, pc + 32'd4, 1'b0, 1'b0);
    next_sample();
    check_cause(dbg_pkg::CAUSE_NONE, pred_o.cause);
    set_debug(1'b0, dbg_pkg::CAUSE_NONE, 1'b1, 1'b0, '0);
    pc = rand_pc();
    retire(NOP_INSN, pc, pc + 32'd4, 1'b0, 1'b0);
    next_sample();
    check_cause(dbg_pkg::CAUSE_STEP, pred_o.cause);
    check_addr(pc + 32'd4, pred_o.dpc);
    set_debug(1'b0, dbg_pkg::CAUSE_NONE, 1'b0, 1'b0, '0);
    end_test();
  endtask

  task automatic test_wfi();
    dbg_pkg::addr_t pc;
    test_name   = "wfi";
    test_errors = errors;
    pc = rand_pc();
    retire(`DBG_WFI_INSN, pc, pc + 32'd4, 1'b0, 1'b0);
    next_sample();
    check_bit(1'b1, in_wfi_o);
    set_lines(1'b0, 1'b1);
    next_sample();
    check_bit(1'b0, in_wfi_o);
    set_lines(1'b0, 1'b0);
    set_debug(1'b0, dbg_pkg::CAUSE_NONE, 1'b1, 1'b0, '0);
    retire(`DBG_WFI_INSN, pc + 32'd4, pc + 32'd8, 1'b0, 1'b0);
    next_sample();
    check_bit(1'b0, in_wfi_o);
    set_debug(1'b0, dbg_pkg::CAUSE_NONE, 1'b0, 1'b0, '0);
    end_test();
  endtask

  task automatic test_dret();
    dbg_pkg::addr_t pc;
    test_name   = "dret";
    test_errors = errors;
    pc = rand_pc();
    retire(NOP_INSN, pc, pc + 32'd4, 1'b0, 1'b0);
    next_sample();
    set_debug(1'b1, dbg_pkg::CAUSE_NONE, 1'b0, 1'b0, pc + 32'd4);
    next_sample();
    check_result(dbg_pkg::ERR_NONE);
    retire(`DBG_DRET_INSN, pc + 32'd4, pc + 32'd8, 1'b0, 1'b0);
    next_sample();
    check_result(dbg_pkg::ERR_DRET_NO_EXIT);
    set_debug(1'b0, dbg_pkg::CAUSE_NONE, 1'b0, 1'b0, '0);
    idle(1);
    retire(`DBG_DRET_INSN, pc, pc + 32'd4, 1'b0, 1'b0);
    next_sample();
    check_result(dbg_pkg::ERR_DRET_NOT_ILLEGAL);
    retire(`DBG_DRET_INSN, pc, pc + 32'd4, 1'b0, 1'b1);
    next_sample();
    check_result(dbg_pkg::ERR_NONE);
    end_test();
  endtask

  initial begin
    rst_i         = 1'b1;
    wb_i          = '0;
    dbg_i         = '0;
    debug_req_i   = 1'b0;
    irq_pending_i = 1'b0;
    checks        = 0;
    errors        = 0;
    tests         = 0;
    repeat (16) @(posedge cov_assert_if);
    rst_i <= 1'b0;
    idle(2);
    test_ebreak_entry();
    test_priority();
    test_haltreq();
    test_single_step();
    test_wfi();
    test_dret();
    idle(4);
    if (pulses != EXP_PULSES) begin
      errors++;
      $display("checker raised %0d error pulses, %0d were expected", pulses, EXP_PULSES);
    end
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+verilog
verilog/dbg_pkg.sv
verilog/dbg_instr_decode.sv
verilog/dbg_cause_tracker.sv
verilog/dbg_entry_checker.sv
verilog/dbg_monitor_top.sv
dv/dbg_monitor_tb.sv

//--- verilog/dbg_cause_tracker.sv
`timescale 1ns/1ps

module dbg_cause_tracker (
  input  logic                 cov_assert_if,
  input  logic                 rst_i,
  input  dbg_pkg::retire_evt_t evt_i,
  input  dbg_pkg::dbg_state_t  dbg_i,
  input  logic                 debug_req_i,
  input  logic                 irq_pending_i,
  output dbg_pkg::predict_t    pred_o,
  output logic                 in_wfi_o
);

  logic              is_ebreak;
  logic              step_ok;
  dbg_pkg::addr_t    last_npc_q;
  dbg_pkg::addr_t    latest_npc;
  dbg_pkg::predict_t pred_d;
  dbg_pkg::predict_t pred_q;
  logic              wfi_set;
  logic              wfi_clr;
  logic              wfi_q;

  assign is_ebreak = (evt_i.cls == dbg_pkg::INSN_EBREAK) ||
                     (evt_i.cls == dbg_pkg::INSN_CEBREAK);

  // Step only overrides a quiet or stepping history
  assign step_ok = (pred_q.cause == dbg_pkg::CAUSE_NONE) ||
                   (pred_q.cause == dbg_pkg::CAUSE_STEP);

  // --------------------
  // Latest next_pc
  // --------------------

  always_ff @(posedge cov_assert_if) begin
    if (rst_i) begin
      last_npc_q <= '0;
    end else if (evt_i.valid) begin
      last_npc_q <= evt_i.next_pc;
    end
  end

  // An event in this cycle is newer than the stored value
  assign latest_npc = evt_i.valid ? evt_i.next_pc : last_npc_q;

  // --------------------
  // Cause priority
  // --------------------

  always_comb begin
    pred_d = pred_q;
    if (!dbg_i.debug_mode) begin
      if (evt_i.valid && evt_i.trigger_hit) begin
        pred_d.cause = dbg_pkg::CAUSE_TRIGGER;
        pred_d.dpc   = evt_i.pc;
      end else if (evt_i.valid && is_ebreak && dbg_i.ebreakm) begin
        pred_d.cause = dbg_pkg::CAUSE_EBREAK;
        pred_d.dpc   = evt_i.pc;
      end else if (debug_req_i) begin
        pred_d.cause = dbg_pkg::CAUSE_HALTREQ;
        pred_d.dpc   = latest_npc;
      end else if (dbg_i.step && step_ok) begin
        pred_d.cause = dbg_pkg::CAUSE_STEP;
        pred_d.dpc   = latest_npc;
      end else if (evt_i.valid) begin
        // Ordinary retirement, nothing pending
        pred_d.cause = dbg_pkg::CAUSE_NONE;
        pred_d.dpc   = evt_i.next_pc;
      end
    end
  end

  always_ff @(posedge cov_assert_if) begin
    if (rst_i) begin
      pred_q.cause <= dbg_pkg::CAUSE_NONE;
      pred_q.dpc   <= '0;
    end else begin
      pred_q <= pred_d;
    end
  end

  assign pred_o = pred_q;

  // --------------------
  // WFI sleep state
  // --------------------

  assign wfi_set = evt_i.valid && (evt_i.cls == dbg_pkg::INSN_WFI) &&
                   !dbg_i.debug_mode && !dbg_i.step && !debug_req_i;

  // Wake-up has priority over a new sleep
  assign wfi_clr = debug_req_i || irq_pending_i;

  always_ff @(posedge cov_assert_if) begin
    if (rst_i) begin
      wfi_q <= 1'b0;
    end else if (wfi_clr) begin
      wfi_q <= 1'b0;
    end else if (wfi_set) begin
      wfi_q <= 1'b1;
    end
  end

  assign in_wfi_o = wfi_q;

  a_pred_hold_in_debug: assert property (
    @(posedge cov_assert_if) disable iff (rst_i)
    dbg_i.debug_mode && $past(dbg_i.debug_mode) |-> $stable(pred_o)
  );

  // Core must have woken before halting
  a_no_sleep_in_debug: assert property (
    @(posedge cov_assert_if) disable iff (rst_i)
    dbg_i.debug_mode |-> !in_wfi_o
  );

endmodule

//--- verilog/dbg_consts.svh
`ifndef DBG_CONSTS_SVH
`define DBG_CONSTS_SVH

// --------------------
// Widths
// --------------------

// Addresses and instruction words
`define DBG_XLEN 32

// dcsr.cause field
`define DBG_CAUSE_W 3

// --------------------
// Instruction encodings
// --------------------

`define DBG_EBREAK_INSN  32'h00100073
// Compressed form, upper half zero
`define DBG_CEBREAK_INSN 32'h00009002
`define DBG_WFI_INSN     32'h10500073
`define DBG_DRET_INSN    32'h7B200073

`endif

//--- verilog/dbg_entry_checker.sv
`timescale 1ns/1ps

module dbg_entry_checker (
  input  logic                 cov_assert_if,
  input  logic                 rst_i,
  input  dbg_pkg::retire_evt_t evt_i,
  input  dbg_pkg::dbg_state_t  dbg_i,
  input  dbg_pkg::predict_t    pred_i,
  output dbg_pkg::chk_result_t result_o
);

  logic              mode_q;
  logic              entry;
  logic              is_dret;
  logic              err_d;
  dbg_pkg::dbg_err_e code_d;
  logic              err_q;
  dbg_pkg::dbg_err_e code_q;
  dbg_pkg::predict_t exp_q;

  // --------------------
  // Event detection
  // --------------------

  always_ff @(posedge cov_assert_if) begin
    if (rst_i) begin
      mode_q <= 1'b0;
    end else begin
      mode_q <= dbg_i.debug_mode;
    end
  end

  assign entry   = dbg_i.debug_mode && !mode_q;
  assign is_dret = evt_i.valid && (evt_i.cls == dbg_pkg::INSN_DRET);

  // --------------------
  // Checks
  // --------------------

  // mode_q is the mode in which the dret retired
  always_comb begin
    err_d  = 1'b0;
    code_d = dbg_pkg::ERR_NONE;
    if (entry && (dbg_i.cause != pred_i.cause)) begin
      err_d  = 1'b1;
      code_d = dbg_pkg::ERR_CAUSE;
    end else if (entry && (dbg_i.dpc != pred_i.dpc)) begin
      err_d  = 1'b1;
      code_d = dbg_pkg::ERR_DPC;
    end else if (is_dret && mode_q && dbg_i.debug_mode) begin
      err_d  = 1'b1;
      code_d = dbg_pkg::ERR_DRET_NO_EXIT;
    end else if (is_dret && !mode_q && !evt_i.illegal) begin
      // dret is illegal in machine mode
      err_d  = 1'b1;
      code_d = dbg_pkg::ERR_DRET_NOT_ILLEGAL;
    end
  end

  always_ff @(posedge cov_assert_if) begin
    if (rst_i) begin
      err_q  <= 1'b0;
      code_q <= dbg_pkg::ERR_NONE;
    end else begin
      err_q  <= err_d;
      code_q <= code_d;
    end
  end

  // Snapshot of the prediction the checks used
  always_ff @(posedge cov_assert_if) begin
    exp_q <= pred_i;
  end

  assign result_o.err       = err_q;
  assign result_o.code      = code_q;
  assign result_o.exp_cause = exp_q.cause;
  assign result_o.exp_dpc   = exp_q.dpc;

  a_err_has_code: assert property (
    @(posedge cov_assert_if) disable iff (rst_i)
    result_o.err |-> (result_o.code != dbg_pkg::ERR_NONE)
  );

endmodule

//--- verilog/dbg_instr_decode.sv
`timescale 1ns/1ps
`include "dbg_consts.svh"

module dbg_instr_decode (
  input  logic                 cov_assert_if,
  input  logic                 rst_i,
  input  dbg_pkg::wb_retire_t  wb_i,
  output dbg_pkg::retire_evt_t evt_o
);

  logic                 fetch_ok;
  dbg_pkg::insn_class_e cls_d;

  logic                 valid_q;
  dbg_pkg::insn_class_e cls_q;
  dbg_pkg::addr_t       pc_q;
  dbg_pkg::addr_t       next_pc_q;
  logic                 trigger_q;
  logic                 illegal_q;

  // --------------------
  // Classification
  // --------------------

  // Faulted or MPU-blocked fetches never count as special instructions
  assign fetch_ok = !wb_i.fetch_err && wb_i.mpu_ok;

  always_comb begin
    cls_d = dbg_pkg::INSN_OTHER;
    if (fetch_ok) begin
      case (wb_i.insn)
        `DBG_EBREAK_INSN:  cls_d = dbg_pkg::INSN_EBREAK;
        `DBG_CEBREAK_INSN: cls_d = dbg_pkg::INSN_CEBREAK;
        `DBG_WFI_INSN:     cls_d = dbg_pkg::INSN_WFI;
        `DBG_DRET_INSN:    cls_d = dbg_pkg::INSN_DRET;
        default:           cls_d = dbg_pkg::INSN_OTHER;
      endcase
    end
  end

  // --------------------
  // Event register
  // --------------------

  always_ff @(posedge cov_assert_if) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= wb_i.valid;
    end
  end

  // Payload only moves on a retirement
  always_ff @(posedge cov_assert_if) begin
    if (wb_i.valid) begin
      cls_q     <= cls_d;
      pc_q      <= wb_i.pc;
      next_pc_q <= wb_i.next_pc;
      trigger_q <= wb_i.trigger_hit;
      illegal_q <= wb_i.illegal;
    end
  end

  assign evt_o.valid       = valid_q;
  assign evt_o.cls         = cls_q;
  assign evt_o.pc          = pc_q;
  assign evt_o.next_pc     = next_pc_q;
  assign evt_o.trigger_hit = trigger_q;
  assign evt_o.illegal     = illegal_q;

  // Back-to-back events need back-to-back retirements
  a_evt_follows_retire: assert property (
    @(posedge cov_assert_if) disable iff (rst_i)
    evt_o.valid && $past(evt_o.valid) |-> $past(wb_i.valid, 1) && $past(wb_i.valid, 2)
  );

endmodule

//--- verilog/dbg_monitor_top.sv
`timescale 1ns/1ps

module dbg_monitor_top (
  input  logic                 cov_assert_if,
  input  logic                 rst_i,
  input  dbg_pkg::wb_retire_t  wb_i,
  input  dbg_pkg::dbg_state_t  dbg_i,
  input  logic                 debug_req_i,
  input  logic                 irq_pending_i,
  output dbg_pkg::predict_t    pred_o,
  output logic                 in_wfi_o,
  output dbg_pkg::chk_result_t result_o
);

  // Decoded retirement, one cycle behind wb_i
  dbg_pkg::retire_evt_t evt;

  dbg_instr_decode u_decode (
    .cov_assert_if (cov_assert_if),
    .rst_i         (rst_i),
    .wb_i          (wb_i),
    .evt_o         (evt)
  );

  // Prediction feeds both the checker and the top output
  dbg_cause_tracker u_tracker (
    .cov_assert_if (cov_assert_if),
    .rst_i         (rst_i),
    .evt_i         (evt),
    .dbg_i         (dbg_i),
    .debug_req_i   (debug_req_i),
    .irq_pending_i (irq_pending_i),
    .pred_o        (pred_o),
    .in_wfi_o      (in_wfi_o)
  );

  dbg_entry_checker u_checker (
    .cov_assert_if (cov_assert_if),
    .rst_i         (rst_i),
    .evt_i         (evt),
    .dbg_i         (dbg_i),
    .pred_i        (pred_o),
    .result_o      (result_o)
  );

endmodule

//--- verilog/dbg_pkg.sv
`include "dbg_consts.svh"

package dbg_pkg;

  // Program counter or dpc value
  typedef logic [`DBG_XLEN-1:0] addr_t;

  // --------------------
  // Enums
  // --------------------

  typedef enum logic [2:0] {
    INSN_OTHER   = 3'd0,
    INSN_EBREAK  = 3'd1,
    INSN_CEBREAK = 3'd2,
    INSN_WFI     = 3'd3,
    INSN_DRET    = 3'd4
  } insn_class_e;

  // Same encoding as dcsr.cause
  typedef enum logic [`DBG_CAUSE_W-1:0] {
    CAUSE_NONE    = 3'd0,
    CAUSE_EBREAK  = 3'd1,
    CAUSE_TRIGGER = 3'd2,
    CAUSE_HALTREQ = 3'd3,
    CAUSE_STEP    = 3'd4
  } dbg_cause_e;

  typedef enum logic [2:0] {
    ERR_NONE             = 3'd0,
    ERR_CAUSE            = 3'd1,
    ERR_DPC              = 3'd2,
    ERR_DRET_NO_EXIT     = 3'd3,
    ERR_DRET_NOT_ILLEGAL = 3'd4
  } dbg_err_e;

  // --------------------
  // Structs
  // --------------------

  // Raw retirement from the core writeback stage
  typedef struct packed {
    logic                valid;
    logic [`DBG_XLEN-1:0] insn;
    addr_t               pc;
    addr_t               next_pc;
    logic                fetch_err;
    logic                mpu_ok;
    logic                trigger_hit;
    logic                illegal;
  } wb_retire_t;

  typedef struct packed {
    logic        valid;
    insn_class_e cls;
    addr_t       pc;
    addr_t       next_pc;
    logic        trigger_hit;
    logic        illegal;
  } retire_evt_t;

  // Core debug CSR view
  typedef struct packed {
    logic       debug_mode;
    dbg_cause_e cause;
    logic       step;
    logic       ebreakm;
    addr_t      dpc;
  } dbg_state_t;

  typedef struct packed {
    dbg_cause_e cause;
    addr_t      dpc;
  } predict_t;

  typedef struct packed {
    logic       err;
    dbg_err_e   code;
    dbg_cause_e exp_cause;
    addr_t      exp_dpc;
  } chk_result_t;

endpackage
